//--- ghrd_fabric.f
+incdir+include
src/ghrd_fabric_pkg.sv
src/key_debounce.sv
src/reset_req_stretcher.sv
src/heartbeat_blinker.sv
src/ghrd_fabric_top.sv
tb/tb_ghrd_fabric.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the fabric testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing -j 0 \
  -f ghrd_fabric.f \
  --top-module tb_ghrd_fabric \
  -o sim_tb \
  && ./obj_dir/sim_tb > "$LOG" 2>&1 \
  || { echo "build or run error"; cat "$LOG" 2>/dev/null; exit 1; }

cat "$LOG"

grep -q "^Simulation passed$" "$LOG" \
  && { echo "PASS"; exit 0; } \
  || { echo "FAIL"; exit 1; }

//--- tb/tb_ghrd_fabric.sv
// table-driven testbench for the fabric top with typed checks and pass/fail report
`timescale 1ns/1ps
`default_nettype none

`include "ghrd_fabric_cfg.svh"

module tb_ghrd_fabric
  import ghrd_fabric_pkg::*;
();

  localparam int DEB_CYC = 8;                 // short debounce for simulation
  localparam int HB_HALF = 20;                // short heartbeat half period

  typedef enum logic [2:0] {
    K_RESET, K_PASS, K_GLITCH, K_PRESS, K_RELEASE, K_PULSE, K_TOGGLE, K_HEART
  } test_kind_e;

  // expected holds the level, length or event word for the row's kind
  typedef struct packed {
    test_kind_e  kind;
    dipsw_t      sw;
    led_pio_t    led_pio;
    button_t     keys;
    logic [1:0]  req_idx;
    logic [31:0] expected;
  } test_row_t;

  logic        fpga_clk_50;
  logic        hps_fpga_reset_n;
  button_t     key;
  dipsw_t      sw;
  led_pio_t    led_pio;
  reset_req_t  reset_req;
  led_t        led;
  reset_req_t  reset_req_n;
  stm_events_t stm_hw_events;

  test_row_t   table_q[$];
  int          errors;
  int          failed;
  int          tests_run;
  bit          timed_out;

  // ==========================================================================
  // clock and DUT
  // ==========================================================================

  always #20 fpga_clk_50 = ~fpga_clk_50;      // 40 ns period

  ghrd_fabric_top #(
    .DEBOUNCE_CYCLES (DEB_CYC),
    .HEARTBEAT_HALF  (HB_HALF)
  ) UUT (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .sw               (sw),
    .led_pio          (led_pio),
    .reset_req        (reset_req),
    .led              (led),
    .reset_req_n      (reset_req_n),
    .stm_hw_events    (stm_hw_events)
  );

  // ==========================================================================
  // helpers and compare tasks
  // ==========================================================================

  task automatic tick();
    @(negedge fpga_clk_50);                   // drive and sample point
  endtask

  task automatic check_led(input string name, input led_t got, input led_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_events(input string name, input stm_events_t got, input stm_events_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_req(input string name, input reset_req_t got, input reset_req_t exp);
    if (got !== exp)
    begin
      errors++;
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_len(input string name, input int got, input int exp);
    if (got != exp)
    begin
      errors++;
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timed_out = 1'b1;                         // stops the test loop
    $display("timeout, %s", what);
  endtask

  // ==========================================================================
  // stimulus table
  // ==========================================================================

  task automatic add_row(input test_kind_e kind, input button_t keys, input int req_idx,
                         input int expected);
    test_row_t r;
    r.kind     = kind;
    r.sw       = dipsw_t'($urandom);
    r.led_pio  = led_pio_t'($urandom);
    r.keys     = keys;
    r.req_idx  = 2'(req_idx);
    r.expected = 32'(expected);
    if (kind == K_PASS)                       // spare zeros, sw, pio, held buttons
      r.expected = {4'b0, 15'b0, r.sw, r.led_pio, keys};
    table_q.push_back(r);
  endtask

  task automatic build_table();
    add_row(K_RESET,   2'b11, 0, 0);
    add_row(K_PASS,    2'b11, 0, 0);
    add_row(K_PASS,    2'b11, 0, 0);
    add_row(K_PASS,    2'b11, 0, 0);
    add_row(K_GLITCH,  2'b10, 0, 2'b11);      // glitch on key 0
    add_row(K_GLITCH,  2'b01, 0, 2'b11);      // glitch on key 1
    add_row(K_PRESS,   2'b10, 0, 2'b10);
    add_row(K_PASS,    2'b10, 0, 0);          // key 0 still held
    add_row(K_RELEASE, 2'b11, 0, 2'b11);
    add_row(K_PRESS,   2'b01, 0, 2'b01);
    add_row(K_RELEASE, 2'b11, 0, 2'b11);
    add_row(K_PRESS,   2'b00, 0, 2'b00);
    add_row(K_PASS,    2'b00, 0, 0);
    add_row(K_RELEASE, 2'b11, 0, 2'b11);
    add_row(K_PULSE,   2'b11, 0, `GHRD_COLD_PULSE);
    add_row(K_PULSE,   2'b11, 1, `GHRD_WARM_PULSE);
    add_row(K_PULSE,   2'b11, 2, `GHRD_DEBUG_PULSE);
    add_row(K_TOGGLE,  2'b11, 2, `GHRD_DEBUG_PULSE);
    add_row(K_HEART,   2'b11, 0, HB_HALF);
    add_row(K_PASS,    2'b11, 0, 0);
    add_row(K_PASS,    2'b11, 0, 0);
  endtask

  // ==========================================================================
  // per-kind test bodies
  // ==========================================================================

  task automatic inject_glitch(input button_t pat, input button_t stable);
    key = pat;
    repeat (4) tick();                        // shorter than the debounce
    key = stable;
    for (int c = 0; c < 20; c++)
    begin
      tick();
      check_events("stm_hw_events[1:0]", {26'b0, stm_hw_events[1:0]}, {26'b0, stable});
    end
  endtask

  task automatic hold_keys(input button_t pat, input button_t exp_lvl);
    int c;
    key = pat;
    c   = 0;
    while (stm_hw_events[1:0] !== exp_lvl && c < 40)
    begin
      tick();
      c++;
    end
    if (stm_hw_events[1:0] !== exp_lvl)
      note_timeout("debounced buttons did not follow the keys within 40 cycles");
    else
      check_events("stm_hw_events", stm_hw_events, {15'b0, sw, led_pio, exp_lvl});
  endtask

  task automatic measure_pulse(input int n, input int exp_len, input bit toggle);
    int         c;
    int         len;
    reset_req_t low_vec;
    low_vec      = ~(reset_req_t'(1) << n);   // only bit n low
    reset_req[n] = 1'b1;
    c            = 0;
    while (reset_req_n[n] !== 1'b0 && c < 10)
    begin
      tick();
      c++;
    end
    if (reset_req_n[n] !== 1'b0)
      note_timeout($sformatf("no low pulse on reset_req_n[%0d]", n));
    else
    begin
      len = 0;
      while (reset_req_n[n] === 1'b0 && len < 100)
      begin
        check_req("reset_req_n", reset_req_n, low_vec);
        if (toggle && len == 5)
          reset_req[n] = 1'b0;
        if (toggle && len == 10)
          reset_req[n] = 1'b1;                // new edge inside the pulse
        tick();
        len++;
      end
      if (len >= 100)
        note_timeout($sformatf("reset_req_n[%0d] never returned high", n));
      check_len("pulse length", len, exp_len);
      for (c = 0; c < 60; c++)                // no second pulse while the request stays high
      begin
        tick();
        check_req("reset_req_n", reset_req_n, '1);
      end
    end
    reset_req[n] = 1'b0;
    repeat (4) tick();                        // let the synchronizer drain
  endtask

  task automatic time_heartbeat(input int exp_period);
    logic prev;
    int   c;
    prev = led[0];
    c    = 0;
    while (led[0] === prev && c < 3 * HB_HALF)
    begin
      tick();
      c++;
    end
    if (led[0] === prev)
      note_timeout("led[0] never toggled");
    else
    begin
      prev = led[0];
      c    = 0;
      while (led[0] === prev && c < 3 * HB_HALF)
      begin
        tick();
        c++;
      end
      if (led[0] === prev)
        note_timeout("led[0] toggled only once");
      else
        check_len("heartbeat period", c, exp_period);
    end
  endtask

  task automatic apply_row(input test_row_t row);
    case (row.kind)
      K_RESET:
      begin
        check_req("reset_req_n", reset_req_n, '1);
        check_led("led[0]", led & 8'h01, 8'h00);
        check_events("stm_hw_events[1:0]", stm_hw_events & 28'h3, 28'h3);
      end
      K_PASS:
      begin
        sw      = row.sw;
        led_pio = row.led_pio;
        key     = row.keys;
        tick();
        check_led("led[7:1]", led & 8'hfe, {row.led_pio, 1'b0});
        check_events("stm_hw_events", stm_hw_events, row.expected[27:0]);
      end
      K_GLITCH:            inject_glitch(row.keys, row.expected[1:0]);
      K_PRESS, K_RELEASE:  hold_keys(row.keys, row.expected[1:0]);
      K_PULSE:             measure_pulse(int'(row.req_idx), int'(row.expected), 1'b0);
      K_TOGGLE:            measure_pulse(int'(row.req_idx), int'(row.expected), 1'b1);
      K_HEART:             time_heartbeat(int'(row.expected));
      default: ;
    endcase
  endtask

  // ==========================================================================
  // main sequence
  // ==========================================================================

  initial
  begin
    test_row_t row;
    int        errs_before;
    bit        ok;
    fpga_clk_50      = 1'b0;
    hps_fpga_reset_n = 1'b0;
    key              = '1;                    // keys released
    sw               = '0;
    led_pio          = '0;
    reset_req        = '0;
    errors           = 0;
    failed           = 0;
    tests_run        = 0;
    timed_out        = 1'b0;
    void'($urandom(32'h218b));                // single seed for the run
    build_table();
    repeat (10) tick();                       // reset held 10 cycles
    hps_fpga_reset_n = 1'b1;
    tick();
    for (int i = 0; i < table_q.size() && !timed_out; i++)
    begin
      row         = table_q[i];
      errs_before = errors;
      apply_row(row);
      tests_run++;
      ok = (errors == errs_before) && !timed_out;
      if (!ok)
        failed++;
      $display("test %0d %s %s", i, row.kind.name(), ok ? "ok" : "FAILED");
    end
    $display("%0d of %0d tests run, %0d failed, %0d check errors",
             tests_run, table_q.size(), failed, errors);
    if (errors == 0 && failed == 0 && !timed_out && tests_run == table_q.size())
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- src/ghrd_fabric_top.sv
// fabric top level with key debounce, reset request pulses, heartbeat, leds and stm events
`timescale 1ns/1ps
`default_nettype none

`include "ghrd_fabric_cfg.svh"

module ghrd_fabric_top
  import ghrd_fabric_pkg::*;
#(
  parameter int DEBOUNCE_CYCLES = `GHRD_DEBOUNCE_CYCLES,
  parameter int HEARTBEAT_HALF  = `GHRD_HEARTBEAT_HALF
)(
  input  logic        fpga_clk_50,
  input  logic        hps_fpga_reset_n,
  input  button_t     key,                    // board keys, active low
  input  dipsw_t      sw,
  input  led_pio_t    led_pio,                // from hps led pio
  input  reset_req_t  reset_req,              // level requests, cold/warm/debug
  output led_t        led,
  output reset_req_t  reset_req_n,            // to hps f2h reset request inputs
  output stm_events_t stm_hw_events
);

  button_t    buttons;                        // debounced, active low
  reset_req_t req_pulse;                      // stretched requests, active high
  logic       hb_beat;

  // ========================================================================
  // key debounce
  // ========================================================================

  key_debounce #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) u_key_debounce (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .key              (key),
    .buttons          (buttons)
  );

  // ========================================================================
  // reset request stretchers
  // ========================================================================

  // cold reset
  reset_req_stretcher #(
    .PULSE_LEN (`GHRD_COLD_PULSE)
  ) u_pulse_cold (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[0]),
    .pulse            (req_pulse[0])
  );

  // warm reset
  reset_req_stretcher #(
    .PULSE_LEN (`GHRD_WARM_PULSE)
  ) u_pulse_warm (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[1]),
    .pulse            (req_pulse[1])
  );

  // debug reset, the long one
  reset_req_stretcher #(
    .PULSE_LEN (`GHRD_DEBUG_PULSE)
  ) u_pulse_debug (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .req              (reset_req[2]),
    .pulse            (req_pulse[2])
  );

  assign reset_req_n = ~req_pulse;            // hps wants active low

  // ========================================================================
  // heartbeat, leds and trace events
  // ========================================================================

  heartbeat_blinker #(
    .HEARTBEAT_HALF (HEARTBEAT_HALF)
  ) u_heartbeat (
    .fpga_clk_50      (fpga_clk_50),
    .hps_fpga_reset_n (hps_fpga_reset_n),
    .beat             (hb_beat)
  );

  // led 0 is the heartbeat, the rest belong to software
  assign led = {led_pio, hb_beat};

  // 15 spare zeros, switches, led pio, buttons in the low bits
  assign stm_hw_events = {15'b0, sw, led_pio, buttons};

endmodule

`default_nettype wire

//--- src/heartbeat_blinker.sv
// free-running heartbeat counter driving one toggling led
`timescale 1ns/1ps
`default_nettype none

`include "ghrd_fabric_cfg.svh"

module heartbeat_blinker #(
  parameter int HEARTBEAT_HALF = `GHRD_HEARTBEAT_HALF
)(
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  output logic beat
);

  // wrap value is HEARTBEAT_HALF-1
  localparam int CNT_W = (HEARTBEAT_HALF > 1) ? $clog2(HEARTBEAT_HALF) : 1;

  logic [CNT_W-1:0] half_cnt;
  logic             wrap;

  assign wrap = (half_cnt == CNT_W'(HEARTBEAT_HALF - 1));

  // ========================================================================
  // half period counter
  // ========================================================================

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      half_cnt <= '0;
      beat     <= 1'b0;                       // led off after reset
    end
    else if (wrap)
    begin
      half_cnt <= '0;
      beat     <= ~beat;                      // toggle once per half period
    end
    else
      half_cnt <= half_cnt + 1'b1;
  end

endmodule

`default_nettype wire

//--- src/reset_req_stretcher.sv
// rising-edge detector that stretches one reset request into a fixed-length pulse
`timescale 1ns/1ps
`default_nettype none

`include "ghrd_fabric_cfg.svh"

module reset_req_stretcher
  import ghrd_fabric_pkg::*;
#(
  parameter int PULSE_LEN = `GHRD_COLD_PULSE
)(
  input  logic fpga_clk_50,
  input  logic hps_fpga_reset_n,
  input  logic req,
  output logic pulse                          // active high, top inverts
);

  localparam int SYNC_STAGES = `GHRD_SYNC_STAGES;
  localparam int CNT_W       = (PULSE_LEN > 1) ? $clog2(PULSE_LEN) : 1;

  logic [SYNC_STAGES-1:0] req_sync;           // bit 0 is first flop
  logic                   req_q;              // edge register
  logic                   req_rise;
  stretcher_state_e       state;
  logic [CNT_W-1:0]       len_cnt;            // cycles already spent in ST_PULSE
  logic                   fsm_rst_n;          // reset held off while busy

  // ========================================================================
  // synchronizer and edge detect
  // ========================================================================

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      req_sync <= '0;
      req_q    <= 1'b0;
    end
    else
    begin
      req_sync[0] <= req;
      for (int k = 1; k < SYNC_STAGES; k++)
        req_sync[k] <= req_sync[k-1];
      req_q <= req_sync[SYNC_STAGES-1];
    end
  end

  assign req_rise = req_sync[SYNC_STAGES-1] & ~req_q;

  // ========================================================================
  // pulse fsm
  // ========================================================================

  // a running pulse masks reset, it lands once the fsm is back in idle
  assign fsm_rst_n = hps_fpga_reset_n | (state == ST_PULSE);

  always_ff @(posedge fpga_clk_50 or negedge fsm_rst_n)
  begin
    if (!fsm_rst_n)
    begin
      state   <= ST_IDLE;
      len_cnt <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          len_cnt <= '0;
          if (req_rise)
            state <= ST_PULSE;                // edges only count here
        end
        ST_PULSE:
        begin
          if (len_cnt == CNT_W'(PULSE_LEN - 1))
          begin
            state   <= ST_IDLE;               // PULSE_LEN cycles done
            len_cnt <= '0;
          end
          else
            len_cnt <= len_cnt + 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign pulse = (state == ST_PULSE);

endmodule

`default_nettype wire

//--- src/key_debounce.sv
// two-key synchronizer and debouncer, active-low keys
`timescale 1ns/1ps
`default_nettype none

`include "ghrd_fabric_cfg.svh"

module key_debounce
  import ghrd_fabric_pkg::*;
#(
  parameter int DEBOUNCE_CYCLES = `GHRD_DEBOUNCE_CYCLES
)(
  input  logic    fpga_clk_50,
  input  logic    hps_fpga_reset_n,
  input  button_t key,
  output button_t buttons
);

  localparam int SYNC_STAGES = `GHRD_SYNC_STAGES;
  localparam int N_KEYS      = $bits(button_t);
  // counter only has to reach DEBOUNCE_CYCLES-1
  localparam int CNT_W       = (DEBOUNCE_CYCLES > 1) ? $clog2(DEBOUNCE_CYCLES) : 1;

  button_t          key_sync [SYNC_STAGES];   // synchronizer chain, [0] is first flop
  logic [CNT_W-1:0] diff_cnt [N_KEYS];        // consecutive differing cycles per key
  button_t          key_s;                    // synchronized key level

  // ========================================================================
  // input synchronizer
  // ========================================================================

  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      for (int k = 0; k < SYNC_STAGES; k++)
        key_sync[k] <= '1;                    // released
    end
    else
    begin
      key_sync[0] <= key;
      for (int k = 1; k < SYNC_STAGES; k++)
        key_sync[k] <= key_sync[k-1];
    end
  end

  assign key_s = key_sync[SYNC_STAGES-1];

  // ========================================================================
  // per-key stability counter
  // ========================================================================

  // each key on its own, output follows only after DEBOUNCE_CYCLES
  // consecutive cycles of disagreement
  always_ff @(posedge fpga_clk_50 or negedge hps_fpga_reset_n)
  begin
    if (!hps_fpga_reset_n)
    begin
      buttons <= '1;                          // all released after reset
      for (int i = 0; i < N_KEYS; i++)
        diff_cnt[i] <= '0;
    end
    else
    begin
      for (int i = 0; i < N_KEYS; i++)
      begin
        if (key_s[i] == buttons[i])
          diff_cnt[i] <= '0;                  // agree again, glitch dropped
        else if (diff_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1))
        begin
          buttons[i]  <= key_s[i];            // stable long enough, accept
          diff_cnt[i] <= '0;
        end
        else
          diff_cnt[i] <= diff_cnt[i] + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/ghrd_fabric_pkg.sv
// vector typedefs and the reset request stretcher state encoding
`default_nettype none

package ghrd_fabric_pkg;

  // ========================================================================
  // board level vectors
  // ========================================================================

  // key / debounced button levels, active low
  typedef logic [1:0] button_t;

  // slide switch value
  typedef logic [3:0] dipsw_t;

  typedef logic [6:0] led_pio_t;      // led value from hps software
  typedef logic [7:0] led_t;          // whole board led bank

  // reset requests, bit 0 cold, bit 1 warm, bit 2 debug
  typedef logic [2:0] reset_req_t;

  // trace event bus into the hps stm
  typedef logic [27:0] stm_events_t;

  // ========================================================================
  // state machines
  // ========================================================================

  // reset request stretcher
  typedef enum logic [0:0] {
    ST_IDLE  = 1'b0,                  // waiting for a rising edge
    ST_PULSE = 1'b1                   // driving the stretched pulse
  } stretcher_state_e;

endpackage

`default_nettype wire

//--- include/ghrd_fabric_cfg.svh
// build-time defaults for debounce, heartbeat, reset request pulses and synchronizers
`ifndef GHRD_FABRIC_CFG_SVH
`define GHRD_FABRIC_CFG_SVH

// ==========================================================================
// key debounce
// ==========================================================================

// stable cycles before a key change is accepted
`define GHRD_DEBOUNCE_CYCLES 50000    // 1 ms at 50 MHz

// ==========================================================================
// heartbeat
// ==========================================================================

// cycles between led toggles, 0.5 s at 50 MHz
`define GHRD_HEARTBEAT_HALF 25000000

// ==========================================================================
// reset request pulse lengths, in fpga_clk_50 cycles
// ==========================================================================

`define GHRD_COLD_PULSE 6             // hps cold reset request
`define GHRD_WARM_PULSE 2             // hps warm reset request
`define GHRD_DEBUG_PULSE 32           // hps debug reset request

// flops in every input synchronizer chain
`define GHRD_SYNC_STAGES 2

`endif
